// ==== Makefile ====
# Verilator build and run for the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_cpu_bus
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
logic/mips_pkg.sv
logic/mips_decoder.sv
logic/mips_alu.sv
logic/mips_regfile.sv
logic/mips_control.sv
logic/mips_cpu_bus.sv
verification/tb_clock.sv
verification/tb_memory.sv
verification/tb_mips_cpu_bus.sv

// ==== logic/mips_alu.sv ====
// Combinational ALU
// Add, subtract, logic, set less than, shifts and load upper

`timescale 1ns/10ps
`default_nettype none

module mips_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result,
    output logic              zero
);
    import mips_pkg::*;

    // Compare results, one bit each
    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            // Set less than gives 1 or 0
            ALU_SLT:  result = {31'd0, lt_signed};
            ALU_SLTU: result = {31'd0, lt_unsigned};
            // Shifts act on operand b
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            // Immediate into the upper half
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // Branch equality check, used with ALU_SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== logic/mips_control.sv ====
// Control unit of the multicycle core
// PC, instruction register, FSM, Avalon master and write-back

`timescale 1ns/10ps
`default_nettype none

module mips_control #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                waitrequest,
    input  mips_pkg::word_t     readdata,
    output mips_pkg::word_t     address,
    output mips_pkg::word_t     writedata,
    output logic                read,
    output logic                write,
    output logic                active,
    output logic [3:0]          byteenable,
    output mips_pkg::word_t     instr,
    input  mips_pkg::decoded_t  decoded,
    output mips_pkg::reg_addr_t rs_addr,
    output mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    output logic                wr_en,
    output mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     alu_a,
    output mips_pkg::word_t     alu_b,
    output mips_pkg::alu_op_t   alu_op,
    input  mips_pkg::word_t     alu_result,
    input  logic                alu_zero
);
    import mips_pkg::*;

    state_t state;
    word_t  pc;
    word_t  ir;

    // Next PC candidates
    word_t  pc_plus4;
    word_t  branch_target;
    word_t  jump_target;
    word_t  next_pc;
    logic   branch_taken;
    logic   mem_op;
    logic   halt_jr;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {decoded.imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], ir[25:0], 2'b00};

    assign branch_taken = (decoded.is_branch_eq && alu_zero) ||
                          (decoded.is_branch_ne && !alu_zero);
    assign mem_op       = decoded.is_load || decoded.is_store;
    // JR to address 0 ends the run
    assign halt_jr      = decoded.is_jump_reg && (rs_data == '0);

    always_comb begin
        if (decoded.is_jump_reg) begin
            next_pc = rs_data;
        end else if (decoded.is_jump) begin
            next_pc = jump_target;
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_VECTOR;
        end else begin
            case (state)
                // Hold the fetch until accepted
                FETCH: if (!waitrequest) state <= DECODE;
                DECODE: state <= EXEC;
                EXEC: begin
                    if (mem_op) begin
                        if (!waitrequest) begin
                            pc    <= next_pc;
                            state <= decoded.is_load ? MEM_WAIT : FETCH;
                        end
                    end else if (halt_jr) begin
                        state <= HALTED;
                    end else begin
                        pc    <= next_pc;
                        state <= FETCH;
                    end
                end
                MEM_WAIT: state <= FETCH;
                HALTED:   state <= HALTED;
                default:  state <= HALTED;
            endcase
        end
    end

    // Instruction arrives one cycle after fetch acceptance
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir <= readdata;
        end
    end

    assign instr = ir;

    // Bus requests, quiet while in reset
    assign read       = !reset &&
                        ((state == FETCH) || ((state == EXEC) && decoded.is_load));
    assign write      = !reset && (state == EXEC) && decoded.is_store;
    assign address    = (state == FETCH) ? pc : alu_result;
    assign writedata  = rt_data;
    assign byteenable = 4'b1111;
    assign active     = (state != HALTED);

    // Operand selection
    assign rs_addr = decoded.rs;
    assign rt_addr = decoded.rt;
    assign alu_a   = rs_data;
    assign alu_b   = decoded.use_imm ? decoded.imm : rt_data;
    assign alu_op  = decoded.alu_op;

    // ALU result in EXEC, load data in MEM_WAIT
    assign wr_addr = decoded.rd;
    assign wr_en   = ((state == EXEC) && decoded.reg_write && !decoded.is_load) ||
                     (state == MEM_WAIT);
    assign wr_data = (state == MEM_WAIT) ? readdata : alu_result;

    a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(read && write));

    // Request held steady under back-pressure
    a_hold_req: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write));

    // Halt is sticky and quiet on the bus
    a_halted: assert property (@(posedge clk) disable iff (reset)
        state == HALTED |=> state == HALTED && !read && !write);

endmodule

`default_nettype wire

// ==== logic/mips_cpu_bus.sv ====
// Top level of the MIPS core with an Avalon-MM master port
// Connects control, decoder, ALU and register file

`timescale 1ns/10ps
`default_nettype none

module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,

    // Avalon master
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    word_t     instr;
    decoded_t  decoded;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t wr_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      wr_en;
    word_t     wr_data;
    word_t     alu_a;
    word_t     alu_b;
    alu_op_t   alu_op;
    word_t     alu_result;
    logic      alu_zero;

    mips_control #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_control (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .active      (active),
        .byteenable  (byteenable),
        .instr       (instr),
        .decoded     (decoded),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .wr_addr     (wr_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .alu_zero    (alu_zero)
    );

    mips_decoder u_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    // Shift amount comes straight from the decoded word
    mips_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .shamt  (decoded.shamt),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

endmodule

`default_nettype wire

// ==== logic/mips_decoder.sv ====
// Instruction decoder for the MIPS subset
// Field split, immediate extension and control flag generation

`timescale 1ns/10ps
`default_nettype none

module mips_decoder (
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t decoded
);
    import mips_pkg::*;

    opcode_t     opcode;
    funct_t      funct;
    logic [15:0] imm16;
    word_t       imm_sext;
    word_t       imm_zext;

    // Raw fields
    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign imm16  = instr[15:0];

    // Sign extension for arithmetic, compares and offsets
    assign imm_sext = {{16{imm16[15]}}, imm16};
    // Zero extension for logic ops and LUI
    assign imm_zext = {16'h0000, imm16};

    always_comb begin
        // Default is a no-op that writes nothing
        decoded        = '0;
        decoded.rs     = instr[25:21];
        decoded.rt     = instr[20:16];
        decoded.rd     = instr[20:16];
        decoded.shamt  = instr[10:6];
        decoded.imm    = imm_sext;
        decoded.alu_op = ALU_ADD;

        case (opcode)
            OPCODE_R: begin
                // R type writes rd
                decoded.rd        = instr[15:11];
                decoded.reg_write = 1'b1;
                case (funct)
                    FUNCT_SLL:  decoded.alu_op = ALU_SLL;
                    FUNCT_SRL:  decoded.alu_op = ALU_SRL;
                    FUNCT_SRA:  decoded.alu_op = ALU_SRA;
                    FUNCT_ADDU: decoded.alu_op = ALU_ADD;
                    FUNCT_SUBU: decoded.alu_op = ALU_SUB;
                    FUNCT_AND:  decoded.alu_op = ALU_AND;
                    FUNCT_OR:   decoded.alu_op = ALU_OR;
                    FUNCT_XOR:  decoded.alu_op = ALU_XOR;
                    FUNCT_SLT:  decoded.alu_op = ALU_SLT;
                    FUNCT_SLTU: decoded.alu_op = ALU_SLTU;
                    FUNCT_JR: begin
                        decoded.reg_write   = 1'b0;
                        decoded.is_jump_reg = 1'b1;
                    end
                    // Unknown funct, no write
                    default: decoded.reg_write = 1'b0;
                endcase
            end
            OPCODE_J: decoded.is_jump = 1'b1;
            OPCODE_BEQ: begin
                // Compare via subtraction
                decoded.alu_op       = ALU_SUB;
                decoded.is_branch_eq = 1'b1;
            end
            OPCODE_BNE: begin
                decoded.alu_op       = ALU_SUB;
                decoded.is_branch_ne = 1'b1;
            end
            OPCODE_ADDIU, OPCODE_SLTI, OPCODE_SLTIU: begin
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.alu_op    = (opcode == OPCODE_ADDIU) ? ALU_ADD :
                                    (opcode == OPCODE_SLTI)  ? ALU_SLT : ALU_SLTU;
            end
            OPCODE_ANDI, OPCODE_ORI, OPCODE_XORI, OPCODE_LUI: begin
                decoded.imm       = imm_zext;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.alu_op    = (opcode == OPCODE_ANDI) ? ALU_AND :
                                    (opcode == OPCODE_ORI)  ? ALU_OR  :
                                    (opcode == OPCODE_XORI) ? ALU_XOR : ALU_LUI;
            end
            OPCODE_LW: begin
                // Address is rs plus offset
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.is_load   = 1'b1;
            end
            OPCODE_SW: begin
                decoded.use_imm  = 1'b1;
                decoded.is_store = 1'b1;
            end
            default: decoded.reg_write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mips_pkg.sv ====
// Shared types for the multicycle MIPS core
// Word and register index types, opcode and funct encodings
// ALU operations, FSM states and the decoded instruction struct

`default_nettype none

package mips_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] reg_addr_t;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OPCODE_R     = 6'd0,
        OPCODE_J     = 6'd2,
        OPCODE_BEQ   = 6'd4,
        OPCODE_BNE   = 6'd5,
        OPCODE_ADDIU = 6'd9,
        OPCODE_SLTI  = 6'd10,
        OPCODE_SLTIU = 6'd11,
        OPCODE_ANDI  = 6'd12,
        OPCODE_ORI   = 6'd13,
        OPCODE_XORI  = 6'd14,
        OPCODE_LUI   = 6'd15,
        OPCODE_LW    = 6'd35,
        OPCODE_SW    = 6'd43
    } opcode_t;

    // R type function codes
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'd0,
        FUNCT_SRL  = 6'd2,
        FUNCT_SRA  = 6'd3,
        FUNCT_JR   = 6'd8,
        FUNCT_ADDU = 6'd33,
        FUNCT_SUBU = 6'd35,
        FUNCT_AND  = 6'd36,
        FUNCT_OR   = 6'd37,
        FUNCT_XOR  = 6'd38,
        FUNCT_SLT  = 6'd42,
        FUNCT_SLTU = 6'd43
    } funct_t;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // Main control FSM
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM_WAIT,
        HALTED
    } state_t;

    // Decoded control word, 64 bits
    typedef struct packed {
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  shamt;
        word_t       imm;
        alu_op_t     alu_op;
        logic        use_imm;
        logic        reg_write;
        logic        is_load;
        logic        is_store;
        logic        is_branch_eq;
        logic        is_branch_ne;
        logic        is_jump;
        logic        is_jump_reg;
    } decoded_t;

endpackage

`default_nettype wire

// ==== logic/mips_regfile.sv ====
// 32 x 32 register file
// Two read ports, one write port, zero register and v0 tap

`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t wr_addr,
    input  logic                wr_en,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // $zero is never written
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // Debug tap on $v0
    assign v0 = regs[2];

    // $zero holds zero whatever the core writes
    a_zero_reg: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// Free running testbench clock, 4 ns period

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// ==== verification/tb_memory.sv ====
// Avalon-MM slave memory model
// Program and data windows, LCG driven waitrequest, read latency of 1
// Load and peek tasks for the testbench

`timescale 1ns/10ps
`default_nettype none

module tb_memory #(
    parameter logic [31:0] PROG_BASE = 32'hBFC00000,
    parameter logic [31:0] DATA_BASE = 32'h00001000
) (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic        waitrequest,
    output logic [31:0] readdata,
    output int          bad_accesses
);
    // 16 words per window
    logic [31:0] prog_mem [16];
    logic [31:0] data_mem [16];
    logic [31:0] lcg_state;
    int          wait_count;
    logic        rd_pending;
    logic [31:0] rd_word;

    initial begin
        lcg_state    = 32'h71cb389e;
        wait_count   = 0;
        rd_pending   = 1'b0;
        rd_word      = '0;
        waitrequest  = 1'b0;
        readdata     = '0;
        bad_accesses = 0;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten words show a value tied to their full address
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base);
        return addr[31:6] == base[31:6];
    endfunction

    task automatic clear_windows();
        for (int i = 0; i < 16; i++) begin
            prog_mem[i] = fill_pattern(PROG_BASE + 32'(i * 4));
            data_mem[i] = fill_pattern(DATA_BASE + 32'(i * 4));
        end
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        if (in_window(addr, PROG_BASE)) begin
            prog_mem[addr[5:2]] = data;
        end else if (in_window(addr, DATA_BASE)) begin
            data_mem[addr[5:2]] = data;
        end else begin
            $display("Error: load outside the memory windows at address %h", addr);
            bad_accesses++;
        end
    endtask

    task automatic peek_word(input logic [31:0] addr, output logic [31:0] data);
        if (in_window(addr, PROG_BASE)) begin
            data = prog_mem[addr[5:2]];
        end else if (in_window(addr, DATA_BASE)) begin
            data = data_mem[addr[5:2]];
        end else begin
            data = fill_pattern(addr);
        end
    endtask

    // Request seen here is the one sampled at the next rising edge
    always @(negedge clk) begin
        // Data of the read accepted at the last rising edge
        if (rd_pending) begin
            readdata = rd_word;
        end
        lcg_state = lcg_next(lcg_state);
        // Random stall, never longer than 3 cycles
        if ((read || write) && (wait_count < 3) && lcg_state[31]) begin
            waitrequest = 1'b1;
            wait_count++;
        end else begin
            waitrequest = 1'b0;
            wait_count  = 0;
        end
        rd_pending = 1'b0;
        if (read && !waitrequest) begin
            if (!in_window(address, PROG_BASE) && !in_window(address, DATA_BASE)) begin
                $display("Error: read outside the memory windows at address %h", address);
                bad_accesses++;
            end
            peek_word(address, rd_word);
            rd_pending = 1'b1;
        end else if (write && !waitrequest) begin
            if ((byteenable != 4'b1111) || !in_window(address, DATA_BASE)) begin
                $display("Error: bad write at address %h with byteenable %b",
                         address, byteenable);
                bad_accesses++;
            end else begin
                data_mem[address[5:2]] = writedata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_mips_cpu_bus.sv ====
// Testbench top for the MIPS core with the Avalon master port
// Program table, per test reset and run, v0 and memory checks, timeout

`timescale 1ns/10ps
`default_nettype none

module tb_mips_cpu_bus;

    localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
    localparam logic [31:0] DATA_BASE    = 32'h00001000;
    localparam int          N_TESTS      = 6;
    localparam int          MAX_INSTR    = 12;
    // Worst case 4 cycles plus two 3 cycle stalls per instruction
    localparam int CYCLE_LIMIT = N_TESTS * (MAX_INSTR * (4 + 2 * 3) + 16 + 10) + 100;
    // jr $zero
    localparam logic [31:0] JR_ZERO = 32'h0000_0008;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    int          bad_accesses;

    // Test table, one row per program
    string       test_name [N_TESTS];
    logic [31:0] prog      [N_TESTS][MAX_INSTR];
    int          prog_len  [N_TESTS];
    logic [31:0] preload   [N_TESTS];
    logic [31:0] exp_v0    [N_TESTS];
    logic [31:0] exp_data  [N_TESTS];

    int          errors;
    int          cycle_count;
    logic [31:0] data_word;

    tb_clock u_clock (
        .clk (clk)
    );

    mips_cpu_bus #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_mips_cpu_bus (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    tb_memory #(
        .PROG_BASE (RESET_VECTOR),
        .DATA_BASE (DATA_BASE)
    ) u_memory (
        .clk          (clk),
        .address      (address),
        .read         (read),
        .write        (write),
        .writedata    (writedata),
        .byteenable   (byteenable),
        .waitrequest  (waitrequest),
        .readdata     (readdata),
        .bad_accesses (bad_accesses)
    );

    // Instruction encoders, fields as in the MIPS I formats
    function automatic logic [31:0] r_word(input int rs, input int rt, input int rd,
                                           input int sh, input int fn);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] i_word(input int op, input int rs, input int rt,
                                           input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] j_word(input int op, input logic [31:0] target);
        return {op[5:0], target[27:2]};
    endfunction

    task automatic set_row(input int t, input string name, input logic [31:0] pre,
                           input logic [31:0] v0, input logic [31:0] data);
        test_name[t] = name;
        preload[t]   = pre;
        exp_v0[t]    = v0;
        exp_data[t]  = data;
        prog_len[t]  = 0;
    endtask

    task automatic push_instr(input int t, input logic [31:0] w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    // Opcodes 4 beq, 5 bne, 2 j, 9 addiu, 10 slti, 11 sltiu, 12 andi, 13 ori
    // 14 xori, 15 lui, 35 lw, 43 sw; functs 0 sll, 2 srl, 3 sra, 33 addu
    // 35 subu, 36 and, 37 or, 38 xor, 42 slt, 43 sltu
    task automatic build_table();
        // Sign and zero extension of immediates
        set_row(0, "imm_ops", 32'h5555_AAAA, 32'h8001_0F02, 32'h0000_0000);
        push_instr(0, i_word(9, 0, 8, -5));
        push_instr(0, i_word(12, 8, 9, 'hF0F0));
        push_instr(0, i_word(13, 9, 9, 'h000F));
        push_instr(0, i_word(14, 9, 9, 'hFFFF));
        push_instr(0, i_word(15, 0, 10, 'h8001));
        push_instr(0, i_word(10, 8, 11, -4));
        push_instr(0, i_word(11, 8, 12, 5));
        push_instr(0, r_word(9, 10, 2, 0, 33));
        push_instr(0, r_word(2, 11, 2, 0, 33));
        push_instr(0, r_word(2, 11, 2, 0, 33));
        push_instr(0, r_word(2, 12, 2, 0, 33));
        push_instr(0, JR_ZERO);
        // Logical and arithmetic shifts of a negative value
        set_row(1, "shift_ops", 32'h5555_AAAA, 32'hFFFF_F0F3, 32'h0000_0000);
        push_instr(1, i_word(9, 0, 8, -16));
        push_instr(1, r_word(0, 8, 10, 2, 3));
        push_instr(1, r_word(0, 8, 11, 28, 2));
        push_instr(1, r_word(0, 11, 12, 8, 0));
        push_instr(1, r_word(10, 11, 2, 0, 38));
        push_instr(1, r_word(2, 12, 2, 0, 38));
        push_instr(1, JR_ZERO);
        // subu, signed and unsigned compares, and, or, addu
        set_row(2, "reg_ops", 32'h5555_AAAA, 32'h0000_000D, 32'h0000_0000);
        push_instr(2, i_word(9, 0, 8, -16));
        push_instr(2, i_word(9, 0, 9, 'h3C));
        push_instr(2, r_word(9, 8, 10, 0, 35));
        push_instr(2, r_word(8, 9, 11, 0, 42));
        push_instr(2, r_word(8, 9, 12, 0, 43));
        push_instr(2, r_word(10, 9, 13, 0, 36));
        push_instr(2, r_word(13, 11, 2, 0, 37));
        push_instr(2, r_word(0, 12, 14, 8, 0));
        push_instr(2, r_word(2, 14, 2, 0, 33));
        push_instr(2, JR_ZERO);
        // Load, compute, store at 0x1004, load it back
        set_row(3, "memory", 32'h1234_5678, 32'h0000_1000, 32'h1234_4688);
        push_instr(3, i_word(9, 0, 8, 'h1000));
        push_instr(3, i_word(35, 8, 9, 0));
        push_instr(3, i_word(9, 9, 2, 'h10));
        push_instr(3, r_word(2, 8, 10, 0, 35));
        push_instr(3, i_word(43, 8, 10, 4));
        push_instr(3, i_word(35, 8, 11, 4));
        push_instr(3, r_word(2, 11, 2, 0, 38));
        push_instr(3, JR_ZERO);
        // Taken beq, untaken bne, j over two writes of v0
        set_row(4, "branches", 32'h5555_AAAA, 32'h0000_0043, 32'h0000_0000);
        push_instr(4, i_word(9, 0, 8, 7));
        push_instr(4, i_word(9, 0, 9, 7));
        push_instr(4, i_word(9, 0, 2, 1));
        push_instr(4, i_word(4, 8, 9, 1));
        push_instr(4, i_word(9, 0, 2, 'h66));
        push_instr(4, i_word(5, 8, 9, 1));
        push_instr(4, i_word(9, 2, 2, 2));
        push_instr(4, j_word(2, RESET_VECTOR + 32'd40));
        push_instr(4, i_word(9, 0, 2, 'h77));
        push_instr(4, i_word(9, 0, 2, 'h55));
        push_instr(4, i_word(13, 2, 2, 'h40));
        push_instr(4, JR_ZERO);
        // Writes to $zero are lost
        set_row(5, "zero_reg", 32'h5555_AAAA, 32'h0000_0000, 32'h0000_0000);
        push_instr(5, i_word(9, 0, 0, 'h1234));
        push_instr(5, i_word(15, 0, 0, 'hFFFF));
        push_instr(5, i_word(9, 0, 2, 'h99));
        push_instr(5, r_word(0, 0, 2, 0, 33));
        push_instr(5, JR_ZERO);
    endtask

    // Run limit over all tests
    initial begin
        cycle_count = 0;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Error: core failed to halt within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset  = 1'b1;
        errors = 0;
        build_table();
        for (int t = 0; t < N_TESTS; t++) begin
            @(negedge clk);
            reset = 1'b1;
            u_memory.clear_windows();
            for (int k = 0; k < prog_len[t]; k++) begin
                u_memory.load_word(RESET_VECTOR + 32'(k * 4), prog[t][k]);
            end
            u_memory.load_word(DATA_BASE, preload[t]);
            u_memory.load_word(DATA_BASE + 32'd4, 32'h0000_0000);
            repeat (16) @(negedge clk);
            // Reset state is active with no bus request
            if ((read !== 1'b0) || (write !== 1'b0) || (active !== 1'b1)) begin
                $display("Error: test %s, bus request or inactive core in reset",
                         test_name[t]);
                errors++;
            end
            reset = 1'b0;
            @(negedge clk);
            if (active !== 1'b1) begin
                $display("Error: test %s, core not active after reset", test_name[t]);
                errors++;
            end
            // Run to the jr $zero
            while (active !== 1'b0) begin
                @(negedge clk);
            end
            if (register_v0 !== exp_v0[t]) begin
                $display("Error: test %s, v0 expected %h, actual %h",
                         test_name[t], exp_v0[t], register_v0);
                errors++;
            end
            u_memory.peek_word(DATA_BASE + 32'd4, data_word);
            if (data_word !== exp_data[t]) begin
                $display("Error: test %s, word at 0x1004 expected %h, actual %h",
                         test_name[t], exp_data[t], data_word);
                errors++;
            end
            // Halted core stays quiet
            repeat (10) begin
                @(negedge clk);
                if ((active !== 1'b0) || (read !== 1'b0) || (write !== 1'b0)) begin
                    $display("Error: test %s, core left the halted state", test_name[t]);
                    errors++;
                end
            end
        end
        $display("Errors: %0d failed checks, %0d bad bus accesses", errors, bad_accesses);
        if ((errors == 0) && (bad_accesses == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
